//--- src/c16_mem_config.svh
//////////////////////////////
// Widths, download indices and fixed addresses of the C16 memory side
// Slot numbers are host address bits 24 to 14, so images sit on 16 KiB steps
//////////////////////////////

`ifndef C16_MEM_CONFIG_SVH
`define C16_MEM_CONFIG_SVH

// Bus widths
`define C16_ADDR_W   16
`define C16_DATA_W   8
`define C16_ROM_AW   14
`define C16_HOST_AW  25
`define C16_IDX_W    8

// Host download indices
`define C16_IDX_ROM   8'd0
`define C16_IDX_PRG   8'd1
`define C16_IDX_CART  8'd2

// ROM slots under the ROM index
`define C16_SLOT_KERNAL   11'd1
`define C16_SLOT_BASIC    11'd2
`define C16_SLOT_FUNC_LO  11'd3
`define C16_SLOT_FUNC_HI  11'd4

// Cartridge halves under the CART index
`define C16_CART_SLOT_LO  11'd0
`define C16_CART_SLOT_HI  11'd1

// Plus-4 bank latch page and the fixed kernal page
`define C16_BANK_PAGE    12'hFDD
`define C16_KERNAL_PAGE  8'hFC

// BASIC start and end pointers patched after a PRG load
`define C16_PTR_0  16'h002D
`define C16_PTR_1  16'h002E
`define C16_PTR_2  16'h002F
`define C16_PTR_3  16'h0030
`define C16_PTR_4  16'h0031
`define C16_PTR_5  16'h0032
`define C16_PTR_6  16'h009D
`define C16_PTR_7  16'h009E

`endif

//--- src/c16_mem_pkg.sv
//////////////////////////////
// Shared types of the memory side
// Bank values above func are not decoded and read as FF
//////////////////////////////

`default_nettype none

`include "c16_mem_config.svh"

package c16_mem_pkg;

	// Fields of a bank latch write at page FDD
	typedef struct packed {
		logic [11:0] page;
		logic [1:0]  rom_hi;
		logic [1:0]  rom_lo;
	} bank_wr_t;

	// Same CPU address, flat or as a bank latch access
	typedef union packed {
		logic [`C16_ADDR_W-1:0] flat;
		bank_wr_t               bank;
	} cpu_addr_u;

	typedef enum logic [1:0] {
		BANK_INTERNAL = 2'd0,
		BANK_CART     = 2'd1,
		BANK_FUNC     = 2'd2
	} bank_sel_t;

	// The six ROM images
	typedef enum logic [2:0] {
		IMG_KERNAL  = 3'd0,
		IMG_BASIC   = 3'd1,
		IMG_FUNC_LO = 3'd2,
		IMG_FUNC_HI = 3'd3,
		IMG_CART_LO = 3'd4,
		IMG_CART_HI = 3'd5
	} rom_img_e;

endpackage

`default_nettype wire

//--- src/prg_loader.sv
//////////////////////////////
// PRG download into main RAM
// First two bytes are the load address, no flow control on the host bus
// Pointer patch takes 16 cycles after the download ends
//////////////////////////////

`default_nettype none

`include "c16_mem_config.svh"

module prg_loader (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    host_download_i,
	input  logic [`C16_IDX_W-1:0]   host_index_i,
	input  logic                    host_wr_i,
	input  logic [`C16_HOST_AW-1:0] host_addr_i,
	input  logic [`C16_DATA_W-1:0]  host_data_i,
	output logic                    ld_we_o,
	output logic [`C16_ADDR_W-1:0]  ld_addr_o,
	output logic [`C16_DATA_W-1:0]  ld_data_o
);

	logic                   dl_q;
	logic                   is_prg;
	logic                   dl_fall;
	logic                   prg_byte;
	logic [`C16_ADDR_W-1:0] run_addr;
	logic [3:0]             seq;

	assign is_prg   = host_index_i == `C16_IDX_PRG;
	assign dl_fall  = dl_q & ~host_download_i & is_prg;
	assign prg_byte = host_download_i & is_prg & host_wr_i & (host_addr_i > `C16_HOST_AW'(1));

	// Pointer location for each of the eight patch writes
	function automatic logic [`C16_ADDR_W-1:0] ptr_addr(input logic [2:0] idx);
		logic [`C16_ADDR_W-1:0] a;
		case (idx)
			3'd0: a = `C16_PTR_0;
			3'd1: a = `C16_PTR_1;
			3'd2: a = `C16_PTR_2;
			3'd3: a = `C16_PTR_3;
			3'd4: a = `C16_PTR_4;
			3'd5: a = `C16_PTR_5;
			3'd6: a = `C16_PTR_6;
			default: a = `C16_PTR_7;
		endcase
		return a;
	endfunction

	// Sequencer runs 1..15 then wraps to idle, odd steps write
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_q    <= 1'b0;
			seq     <= 4'd0;
			ld_we_o <= 1'b0;
		end else begin
			dl_q    <= host_download_i;
			ld_we_o <= prg_byte | seq[0];
			if (host_download_i && is_prg)
				seq <= 4'd0;
			else if (dl_fall)
				seq <= 4'd1;
			else if (seq != 4'd0)
				seq <= seq + 4'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (host_download_i && is_prg && host_wr_i) begin
			if (host_addr_i == `C16_HOST_AW'(0))
				run_addr[7:0] <= host_data_i;
			else if (host_addr_i == `C16_HOST_AW'(1))
				run_addr[15:8] <= host_data_i;
			else
				run_addr <= run_addr + 16'd1;
		end
		if (prg_byte) begin
			ld_addr_o <= run_addr;
			ld_data_o <= host_data_i;
		end else if (seq[0]) begin
			// Low byte first, then high byte
			ld_addr_o <= ptr_addr(seq[3:1]);
			ld_data_o <= seq[1] ? run_addr[15:8] : run_addr[7:0];
		end
	end

endmodule

`default_nettype wire

//--- src/main_ram.sv
//////////////////////////////
// 64 KiB main RAM, host write port and CPU port
// CPU write lands one cycle after the select is released
//////////////////////////////

`default_nettype none

`include "c16_mem_config.svh"

module main_ram (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ld_we_i,
	input  logic [`C16_ADDR_W-1:0] ld_addr_i,
	input  logic [`C16_DATA_W-1:0] ld_data_i,
	input  c16_mem_pkg::cpu_addr_u cpu_addr_i,
	input  logic [`C16_DATA_W-1:0] cpu_data_i,
	input  logic                   cpu_rnw_i,
	input  logic                   cs_ram_n_i,
	output logic [`C16_DATA_W-1:0] ram_q_o
);

	logic [`C16_DATA_W-1:0] mem [0:(1<<`C16_ADDR_W)-1];
	logic                   cs_q;
	logic                   ram_we;

	// Rising edge of the active-low select ends a CPU access
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cs_q   <= 1'b1;
			ram_we <= 1'b0;
		end else begin
			cs_q   <= cs_ram_n_i;
			ram_we <= ~cs_q & cs_ram_n_i & ~cpu_rnw_i;
		end
	end

	// CPU port wins when both ports hit the same address
	always_ff @(posedge clk_sys) begin
		if (ld_we_i)
			mem[ld_addr_i] <= ld_data_i;
		if (ram_we)
			mem[cpu_addr_i.flat] <= cpu_data_i;
		ram_q_o <= cs_ram_n_i ? '1 : mem[cpu_addr_i.flat];
	end

endmodule

`default_nettype wire

//--- src/rom_store.sv
//////////////////////////////
// Six 16 KiB ROM images loaded by the host
// Images start empty, reads of an unloaded image are undefined
//////////////////////////////

`default_nettype none

`include "c16_mem_config.svh"

module rom_store (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    host_download_i,
	input  logic [`C16_IDX_W-1:0]   host_index_i,
	input  logic                    host_wr_i,
	input  logic [`C16_HOST_AW-1:0] host_addr_i,
	input  logic [`C16_DATA_W-1:0]  host_data_i,
	input  logic                    plus4_i,
	input  logic                    rd_en_i,
	input  c16_mem_pkg::rom_img_e   rd_img_i,
	input  c16_mem_pkg::cpu_addr_u  cpu_addr_i,
	output logic [`C16_DATA_W-1:0]  rom_q_o,
	output logic                    cart_lo_present_o,
	output logic                    cart_hi_present_o,
	output logic                    cart_loading_o
);

	import c16_mem_pkg::*;

	logic [`C16_DATA_W-1:0]                 img_mem [0:5][0:(1<<`C16_ROM_AW)-1];
	logic [`C16_HOST_AW-`C16_ROM_AW-1:0]    slot;
	logic                                   wr_hit;
	rom_img_e                               wr_img;
	logic                                   wr_pend;
	rom_img_e                               wr_img_q;
	logic [`C16_ROM_AW-1:0]                 wr_off_q;
	logic [`C16_DATA_W-1:0]                 wr_data_q;

	assign slot           = host_addr_i[`C16_HOST_AW-1:`C16_ROM_AW];
	assign cart_loading_o = plus4_i & host_download_i & (host_index_i == `C16_IDX_CART);

	// Host write decode by index and slot
	always_comb begin
		wr_hit = 1'b0;
		wr_img = IMG_KERNAL;
		if (host_download_i && host_wr_i) begin
			if (host_index_i == `C16_IDX_ROM) begin
				wr_hit = 1'b1;
				case (slot)
					`C16_SLOT_KERNAL:  wr_img = IMG_KERNAL;
					`C16_SLOT_BASIC:   wr_img = IMG_BASIC;
					`C16_SLOT_FUNC_LO: wr_img = IMG_FUNC_LO;
					`C16_SLOT_FUNC_HI: wr_img = IMG_FUNC_HI;
					default:           wr_hit = 1'b0;
				endcase
			end else if (host_index_i == `C16_IDX_CART) begin
				wr_hit = 1'b1;
				case (slot)
					`C16_CART_SLOT_LO: wr_img = IMG_CART_LO;
					`C16_CART_SLOT_HI: wr_img = IMG_CART_HI;
					default:           wr_hit = 1'b0;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_pend           <= 1'b0;
			cart_lo_present_o <= 1'b0;
			cart_hi_present_o <= 1'b0;
		end else begin
			wr_pend <= wr_hit;
			if (wr_hit && wr_img == IMG_CART_LO)
				cart_lo_present_o <= 1'b1;
			if (wr_hit && wr_img == IMG_CART_HI)
				cart_hi_present_o <= 1'b1;
		end
	end

	// Write one cycle after the host strobe, read every cycle
	always_ff @(posedge clk_sys) begin
		wr_img_q  <= wr_img;
		wr_off_q  <= host_addr_i[`C16_ROM_AW-1:0];
		wr_data_q <= host_data_i;
		if (wr_pend)
			img_mem[wr_img_q][wr_off_q] <= wr_data_q;
		rom_q_o <= rd_en_i ? img_mem[rd_img_i][cpu_addr_i.flat[`C16_ROM_AW-1:0]] : '1;
	end

endmodule

`default_nettype wire

//--- src/bank_ctrl.sv
//////////////////////////////
// Model and bank latches, ROM read select, read data merge
// Bank latch only accepts writes in Plus-4 mode
//////////////////////////////

`default_nettype none

`include "c16_mem_config.svh"

module bank_ctrl (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   model_i,
	input  c16_mem_pkg::cpu_addr_u cpu_addr_i,
	input  logic                   cpu_rnw_i,
	input  logic                   cs0_n_i,
	input  logic                   cs1_n_i,
	input  logic                   cs_io_n_i,
	input  logic                   cart_lo_present_i,
	input  logic                   cart_hi_present_i,
	input  logic                   cart_loading_i,
	input  logic [`C16_DATA_W-1:0] ram_q_i,
	input  logic [`C16_DATA_W-1:0] rom_q_i,
	output logic                   cpu_reset_o,
	output logic                   plus4_o,
	output logic                   rd_en_o,
	output c16_mem_pkg::rom_img_e  rd_img_o,
	output logic [`C16_DATA_W-1:0] cpu_din_o
);

	import c16_mem_pkg::*;

	bank_sel_t rom_hi_q;
	bank_sel_t rom_lo_q;
	logic      io_q;
	logic      kern_page;
	logic      bank_wr;

	// Cartridge load in Plus-4 mode holds the CPU in reset
	assign cpu_reset_o = reset | cart_loading_i;
	assign kern_page   = cpu_addr_i.flat[15:8] == `C16_KERNAL_PAGE;
	assign bank_wr     = plus4_o & ~io_q & cs_io_n_i & ~cpu_rnw_i
		& (cpu_addr_i.bank.page == `C16_BANK_PAGE);

	always_ff @(posedge clk_sys) begin
		if (reset)
			io_q <= 1'b1;
		else
			io_q <= cs_io_n_i;
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_reset_o) begin
			plus4_o  <= model_i;
			rom_hi_q <= BANK_INTERNAL;
			rom_lo_q <= BANK_INTERNAL;
		end else if (bank_wr) begin
			rom_hi_q <= bank_sel_t'(cpu_addr_i.bank.rom_hi);
			rom_lo_q <= bank_sel_t'(cpu_addr_i.bank.rom_lo);
		end
	end

	//////////////////////////////
	// ROM select
	//////////////////////////////
	always_comb begin
		rd_en_o  = 1'b0;
		rd_img_o = IMG_KERNAL;
		if (!cs0_n_i) begin
			case (rom_lo_q)
				BANK_INTERNAL: {rd_en_o, rd_img_o} = {1'b1, IMG_BASIC};
				BANK_CART:     {rd_en_o, rd_img_o} = {cart_lo_present_i, IMG_CART_LO};
				BANK_FUNC:     {rd_en_o, rd_img_o} = {1'b1, IMG_FUNC_LO};
				default:       rd_en_o = 1'b0;
			endcase
		end else if (!cs1_n_i) begin
			if (kern_page)
				rd_en_o = 1'b1;
			else begin
				case (rom_hi_q)
					BANK_INTERNAL: rd_en_o = 1'b1;
					BANK_CART:     {rd_en_o, rd_img_o} = {cart_hi_present_i, IMG_CART_HI};
					BANK_FUNC:     {rd_en_o, rd_img_o} = {1'b1, IMG_FUNC_HI};
					default:       rd_en_o = 1'b0;
				endcase
			end
		end
	end

	// Unselected sources idle at FF
	assign cpu_din_o = ram_q_i & rom_q_i;

endmodule

`default_nettype wire

//--- src/c16_mem_top.sv
//////////////////////////////
// Memory side of the C16 and Plus-4
// CPU and TED core sit outside, single clock domain
//////////////////////////////

`default_nettype none

`include "c16_mem_config.svh"

module c16_mem_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    model_i,
	input  logic                    host_download_i,
	input  logic [`C16_IDX_W-1:0]   host_index_i,
	input  logic                    host_wr_i,
	input  logic [`C16_HOST_AW-1:0] host_addr_i,
	input  logic [`C16_DATA_W-1:0]  host_data_i,
	input  c16_mem_pkg::cpu_addr_u  cpu_addr_i,
	input  logic [`C16_DATA_W-1:0]  cpu_data_i,
	input  logic                    cpu_rnw_i,
	input  logic                    cs_ram_n_i,
	input  logic                    cs0_n_i,
	input  logic                    cs1_n_i,
	input  logic                    cs_io_n_i,
	output logic [`C16_DATA_W-1:0]  cpu_din_o,
	output logic                    cpu_reset_o
);

	import c16_mem_pkg::*;

	// Loader to RAM port A
	logic                   ld_we;
	logic [`C16_ADDR_W-1:0] ld_addr;
	logic [`C16_DATA_W-1:0] ld_data;

	// Read data and ROM control
	logic [`C16_DATA_W-1:0] ram_q;
	logic [`C16_DATA_W-1:0] rom_q;
	logic                   plus4;
	logic                   rd_en;
	rom_img_e               rd_img;
	logic                   cart_lo_present;
	logic                   cart_hi_present;
	logic                   cart_loading;

	prg_loader prg_loader0 (
		.clk_sys, .reset, .host_download_i, .host_index_i, .host_wr_i, .host_addr_i,
		.host_data_i, .ld_we_o(ld_we), .ld_addr_o(ld_addr), .ld_data_o(ld_data)
	);

	main_ram main_ram0 (
		.clk_sys, .reset, .ld_we_i(ld_we), .ld_addr_i(ld_addr), .ld_data_i(ld_data),
		.cpu_addr_i, .cpu_data_i, .cpu_rnw_i, .cs_ram_n_i, .ram_q_o(ram_q)
	);

	rom_store rom_store0 (
		.clk_sys, .reset, .host_download_i, .host_index_i, .host_wr_i, .host_addr_i,
		.host_data_i, .plus4_i(plus4), .rd_en_i(rd_en), .rd_img_i(rd_img), .cpu_addr_i,
		.rom_q_o(rom_q), .cart_lo_present_o(cart_lo_present),
		.cart_hi_present_o(cart_hi_present), .cart_loading_o(cart_loading)
	);

	bank_ctrl bank_ctrl0 (
		.clk_sys, .reset, .model_i, .cpu_addr_i, .cpu_rnw_i, .cs0_n_i, .cs1_n_i, .cs_io_n_i,
		.cart_lo_present_i(cart_lo_present), .cart_hi_present_i(cart_hi_present),
		.cart_loading_i(cart_loading), .ram_q_i(ram_q), .rom_q_i(rom_q),
		.cpu_reset_o, .plus4_o(plus4), .rd_en_o(rd_en), .rd_img_o(rd_img), .cpu_din_o
	);

endmodule

`default_nettype wire

//--- test/tb_c16_mem.sv
//////////////////////////////
// Replays test/c16_mem_stim.txt against the memory top level
// Run from the project root so the stim path resolves
//////////////////////////////

`default_nettype none

`include "c16_mem_config.svh"

module tb_c16_mem;

	timeunit 1ns;
	timeprecision 1ps;

	import c16_mem_pkg::*;

	logic                    clk_sys;
	logic                    reset;
	logic                    model_i;
	logic                    host_download_i;
	logic [`C16_IDX_W-1:0]   host_index_i;
	logic                    host_wr_i;
	logic [`C16_HOST_AW-1:0] host_addr_i;
	logic [`C16_DATA_W-1:0]  host_data_i;
	cpu_addr_u               cpu_addr_i;
	logic [`C16_DATA_W-1:0]  cpu_data_i;
	logic                    cpu_rnw_i;
	logic                    cs_ram_n_i;
	logic                    cs0_n_i;
	logic                    cs1_n_i;
	logic                    cs_io_n_i;
	logic [`C16_DATA_W-1:0]  cpu_din_o;
	logic                    cpu_reset_o;

	int          fd;
	int          code;
	int          lines;
	int          errors;
	int          fails;
	string       op;
	string       name;
	string       rest;
	logic [31:0] addr;
	logic [31:0] data;

	c16_mem_top dut0 (.*);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	// Every wait below is a counted number of falling edges
	task automatic run_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(negedge clk_sys);
	endtask

	task automatic apply_model(input logic plus4);
		model_i = plus4;
		reset   = 1'b1;
		run_cycles(10);
		reset   = 1'b0;
	endtask

	// Stim address carries the download index in bits 31 to 28
	task automatic host_byte(input logic [31:0] a, input logic [7:0] d);
		host_download_i = 1'b1;
		host_index_i    = {4'd0, a[31:28]};
		host_addr_i     = a[`C16_HOST_AW-1:0];
		host_data_i     = d;
		host_wr_i       = 1'b1;
		run_cycles(1);
		host_wr_i       = 1'b0;
	endtask

	task automatic end_download(input int n);
		host_download_i = 1'b0;
		run_cycles(n);
	endtask

	// Address and data stay put for two cycles after the select rises
	task automatic ram_write(input logic [15:0] a, input logic [7:0] d);
		cpu_addr_i.flat = a;
		cpu_data_i      = d;
		cpu_rnw_i       = 1'b0;
		cs_ram_n_i      = 1'b0;
		run_cycles(1);
		cs_ram_n_i      = 1'b1;
		run_cycles(2);
		cpu_rnw_i       = 1'b1;
	endtask

	task automatic bank_write(input logic [15:0] a);
		cpu_addr_i.flat = a;
		cpu_rnw_i       = 1'b0;
		cs_io_n_i       = 1'b0;
		run_cycles(1);
		cs_io_n_i       = 1'b1;
		run_cycles(1);
		cpu_rnw_i       = 1'b1;
	endtask

	// Select follows the address map, data is back one cycle later
	task automatic cpu_read(input logic [15:0] a, input logic [7:0] exp, input string tname);
		cpu_addr_i.flat = a;
		if (a[15:14] == 2'b11)
			cs1_n_i = 1'b0;
		else if (a[15])
			cs0_n_i = 1'b0;
		else
			cs_ram_n_i = 1'b0;
		run_cycles(1);
		if (cpu_din_o !== exp) begin
			errors++;
			$display("ERROR %s: expected %02h, actual %02h", tname, exp, cpu_din_o);
		end
		cs_ram_n_i = 1'b1;
		cs0_n_i    = 1'b1;
		cs1_n_i    = 1'b1;
	endtask

	task automatic expect_reset(input logic exp, input string tname);
		int n;
		n = 0;
		run_cycles(1);
		while (cpu_reset_o !== exp && n < 4) begin
			run_cycles(1);
			n++;
		end
		if (cpu_reset_o !== exp) begin
			errors++;
			$display("ERROR %s: expected %0b, actual %0b", tname, exp, cpu_reset_o);
		end
	endtask

	task automatic replay_op(input string o, input logic [31:0] a, input logic [31:0] d,
		input string tname);
		case (o)
			"M": apply_model(d[0]);
			"H": host_byte(a, d[7:0]);
			"E": end_download(int'(d[7:0]));
			"W": ram_write(a[15:0], d[7:0]);
			"B": bank_write(a[15:0]);
			"C": cpu_read(a[15:0], d[7:0], tname);
			"R": expect_reset(d[0], tname);
			default: begin
				fails++;
				$display("Unknown operation %s in line for %s", o, tname);
			end
		endcase
	endtask

	initial begin
		reset           = 1'b1;
		model_i         = 1'b0;
		host_download_i = 1'b0;
		host_index_i    = '0;
		host_wr_i       = 1'b0;
		host_addr_i     = '0;
		host_data_i     = '0;
		cpu_addr_i      = '0;
		cpu_data_i      = '0;
		cpu_rnw_i       = 1'b1;
		cs_ram_n_i      = 1'b1;
		cs0_n_i         = 1'b1;
		cs1_n_i         = 1'b1;
		cs_io_n_i       = 1'b1;
		errors          = 0;
		fails           = 0;
		lines           = 0;
		run_cycles(10);
		reset = 1'b0;

		fd = $fopen("test/c16_mem_stim.txt", "r");
		if (fd == 0) begin
			fails++;
			$display("Stimulus file test/c16_mem_stim.txt could not be opened");
		end else begin
			while (!$feof(fd) && lines < 500) begin
				lines++;
				code = $fscanf(fd, " %s", op);
				if (code == 1) begin
					if (op.getc(0) == "#") begin
						code = $fgets(rest, fd);
					end else begin
						code = $fscanf(fd, " %h %h %s", addr, data, name);
						if (code != 3) begin
							fails++;
							$display("Malformed stimulus line after operation %s", op);
						end else begin
							replay_op(op, addr, data, name);
						end
					end
				end
			end
			$fclose(fd);
		end

		$display("Value errors: %0d, other failures: %0d", errors, fails);
		if (errors == 0 && fails == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/c16_mem_stim.txt
# op addr data name. addr and data are hex, H addr is {index[31:28], host address}
# M model, H host byte, E end download (data = cycles), W ram write, B bank write, C read, R reset
H 10000000 01 prg_load_lo
H 10000001 10 prg_load_hi
H 10000002 a9 prg_d0
H 10000003 5c prg_d1
H 10000004 e3 prg_d2
H 10000005 17 prg_d3
E 10000000 14 prg_end
C 00001001 a9 ram_1001
C 00001002 5c ram_1002
C 00001004 17 ram_1004
C 0000002d 05 ptr_2d
C 0000002e 10 ptr_2e
C 00000031 05 ptr_31
C 0000009e 10 ptr_9e
H 00007c10 4e rom_kern_fc10
H 00006000 b3 rom_kern_e000
H 00008000 27 rom_basic_8000
H 0000c000 91 rom_flo_8000
H 00012000 6d rom_fhi_e000
H 00013c10 d8 rom_fhi_fc10
E 00000000 04 rom_end
C 0000fc10 4e c16_kern_fc10
C 0000e000 b3 c16_kern_e000
C 00008000 27 c16_basic
B 0000fdda 00 c16_bank_ignored
C 00008000 27 c16_basic_again
M 00000000 01 set_plus4
B 0000fdda 00 p4_bank_func
C 00008000 91 p4_func_lo
C 0000e000 6d p4_func_hi
C 0000fc10 4e p4_kern_page
B 0000fdd5 00 p4_bank_cart
C 00008000 ff p4_no_cart
H 20000000 c4 cart_lo_byte
R 00000000 01 cart_holds_reset
H 20004000 5e cart_hi_byte
E 20000000 04 cart_end
R 00000000 00 cart_releases_reset
C 00008000 27 p4_internal_again
B 0000fdd5 00 p4_bank_cart2
C 00008000 c4 cart_lo_read
C 0000c000 5e cart_hi_read
W 00004321 a7 ram_write
C 00004321 a7 ram_readback

//--- src.f
+incdir+src
src/c16_mem_pkg.sv
src/prg_loader.sv
src/main_ram.sv
src/rom_store.sv
src/bank_ctrl.sv
src/c16_mem_top.sv
test/tb_c16_mem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the C16 memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f src.f \
	--top-module tb_c16_mem -Mdir obj_dir -o tb_c16_mem

out=$(./obj_dir/tb_c16_mem)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TB PASSED"
